// ==== design/bus_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_decoder
    import bus_pkg::*;
#(
    parameter int NUM_BANKS   = 4,
    parameter int BANK_WORDS  = 64,
    parameter int QUEUE_DEPTH = 2,
    localparam int SEL_W      = $clog2(NUM_BANKS),
    localparam int INDEX_W    = $clog2(BANK_WORDS),
    localparam int SRC_W      = $clog2(NUM_BANKS + 1),
    localparam int CRED_W     = $clog2(QUEUE_DEPTH + 1)
) (
    input  wire logic                 CLOCK_50,
    input  wire logic                 KEY0,
    // cpu side
    input  wire logic [ADDR_W-1:0]    bus_address,
    input  wire data_t                bus_write_data,
    input  wire logic                 bus_write_enable,
    input  wire logic                 bus_read_enable,
    output logic                      bus_ready,
    // ram banks
    output logic [NUM_BANKS-1:0]      bank_req_valid,
    output logic                      bank_req_write,
    output logic [INDEX_W-1:0]        bank_req_index,
    output data_t                     bank_req_data,
    input  wire logic [NUM_BANKS-1:0] bank_credit_return,
    // console
    output logic                      con_req_valid,
    output logic                      con_req_write,
    output logic [OFS_W-1:0]          con_req_offset,
    output data_t                     con_req_data,
    input  wire logic                 con_credit_return,
    // read order to the merger
    output logic                      ord_push,
    output logic [SRC_W-1:0]          ord_source
);

    bus_addr_u         addr;
    logic              is_ram;
    logic [SEL_W-1:0]  sel;
    logic [CRED_W-1:0] bank_credit [NUM_BANKS];
    logic              con_credit;
    logic              accept;
    logic              accept_ram;
    logic              accept_con;

    // ====================
    // decode
    // ====================
    assign addr   = bus_address;
    assign is_ram = (addr.ram.region == RAM_REGION);
    // word interleave on the low word bits
    assign sel    = addr.ram.word[SEL_W-1:0];

    // stall only when the addressed target is out of credit
    assign bus_ready  = is_ram ? (bank_credit[sel] != '0) : con_credit;
    assign accept     = (bus_read_enable || bus_write_enable) && bus_ready;
    assign accept_ram = accept && is_ram;
    assign accept_con = accept && !is_ram;

    // ====================
    // credits
    // ====================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_credit[b] <= CRED_W'(QUEUE_DEPTH);
            end
            con_credit <= 1'b1;
        end else begin
            // taken at acceptance, back when the bank lets go
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_credit[b] <= bank_credit[b]
                    - CRED_W'(accept_ram && (sel == SEL_W'(b)))
                    + CRED_W'(bank_credit_return[b]);
            end
            // single console credit, never taken and returned together
            if (accept_con) begin
                con_credit <= 1'b0;
            end else if (con_credit_return) begin
                con_credit <= 1'b1;
            end
        end
    end

    // ====================
    // issue register
    // ====================
    // request shows up at the target one cycle after acceptance
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bank_req_valid <= '0;
            con_req_valid  <= 1'b0;
            ord_push       <= 1'b0;
        end else begin
            bank_req_valid <= '0;
            if (accept_ram) begin
                bank_req_valid[sel] <= 1'b1;
            end
            con_req_valid <= accept_con;
            // reads only, writes get no response
            ord_push      <= accept && !bus_write_enable;
        end
    end

    // payload, shared by all targets
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            bank_req_write <= bus_write_enable;
            bank_req_index <= addr.ram.word[SEL_W +: INDEX_W];
            bank_req_data  <= bus_write_data;
            con_req_write  <= bus_write_enable;
            con_req_offset <= addr.mmio.offset;
            con_req_data   <= bus_write_data;
            // console source sits one past the last bank
            ord_source     <= is_ram ? SRC_W'(sel) : SRC_W'(NUM_BANKS);
        end
    end

endmodule

`default_nettype wire

// ==== design/bus_fabric_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_fabric_top
    import bus_pkg::*;
#(
    parameter int NUM_BANKS   = 4,
    parameter int BANK_WORDS  = 64,
    parameter int QUEUE_DEPTH = 2,
    localparam int INDEX_W    = $clog2(BANK_WORDS),
    localparam int SRC_W      = $clog2(NUM_BANKS + 1)
) (
    input  wire logic              CLOCK_50,
    input  wire logic              KEY0,
    // cpu port
    input  wire logic [ADDR_W-1:0] bus_address,
    input  wire data_t             bus_write_data,
    input  wire logic              bus_write_enable,
    input  wire logic              bus_read_enable,
    output logic                   bus_ready,
    output logic                   bus_read_done,
    output data_t                  bus_read_data,
    // keyboard and uart
    input  wire logic              key_valid,
    input  wire logic [7:0]        key_ascii,
    output logic                   irq,
    output logic                   uart_valid,
    output logic [7:0]             uart_data
);

    // decoder to banks
    logic [NUM_BANKS-1:0] bank_req_valid;
    logic                 bank_req_write;
    logic [INDEX_W-1:0]   bank_req_index;
    data_t                bank_req_data;
    logic [NUM_BANKS-1:0] bank_credit_return;
    // banks to merger
    logic [NUM_BANKS-1:0] bank_rsp_valid;
    data_t                bank_rsp_data [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_rsp_take;
    // console links
    logic                 con_req_valid;
    logic                 con_req_write;
    logic [OFS_W-1:0]     con_req_offset;
    data_t                con_req_data;
    logic                 con_credit_return;
    logic                 con_rsp_valid;
    data_t                con_rsp_data;
    logic                 con_rsp_take;
    // issue order
    logic                 ord_push;
    logic [SRC_W-1:0]     ord_source;

    // ====================
    // request side
    // ====================
    bus_decoder #(
        .NUM_BANKS   (NUM_BANKS),
        .BANK_WORDS  (BANK_WORDS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) decoder_i (
        .CLOCK_50           (CLOCK_50),
        .KEY0               (KEY0),
        .bus_address        (bus_address),
        .bus_write_data     (bus_write_data),
        .bus_write_enable   (bus_write_enable),
        .bus_read_enable    (bus_read_enable),
        .bus_ready          (bus_ready),
        .bank_req_valid     (bank_req_valid),
        .bank_req_write     (bank_req_write),
        .bank_req_index     (bank_req_index),
        .bank_req_data      (bank_req_data),
        .bank_credit_return (bank_credit_return),
        .con_req_valid      (con_req_valid),
        .con_req_write      (con_req_write),
        .con_req_offset     (con_req_offset),
        .con_req_data       (con_req_data),
        .con_credit_return  (con_credit_return),
        .ord_push           (ord_push),
        .ord_source         (ord_source)
    );

    // word interleaved banks
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        ram_bank #(
            .BANK_WORDS  (BANK_WORDS),
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) bank_i (
            .CLOCK_50      (CLOCK_50),
            .KEY0          (KEY0),
            .req_valid     (bank_req_valid[g]),
            .req_write     (bank_req_write),
            .req_index     (bank_req_index),
            .req_data      (bank_req_data),
            .credit_return (bank_credit_return[g]),
            .rsp_valid     (bank_rsp_valid[g]),
            .rsp_data      (bank_rsp_data[g]),
            .rsp_take      (bank_rsp_take[g])
        );
    end

    console_regs console_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .req_valid     (con_req_valid),
        .req_write     (con_req_write),
        .req_offset    (con_req_offset),
        .req_data      (con_req_data),
        .credit_return (con_credit_return),
        .rsp_valid     (con_rsp_valid),
        .rsp_data      (con_rsp_data),
        .rsp_take      (con_rsp_take),
        .key_valid     (key_valid),
        .key_ascii     (key_ascii),
        .irq           (irq),
        .uart_valid    (uart_valid),
        .uart_data     (uart_data)
    );

    // ====================
    // response side
    // ====================
    read_merge #(
        .NUM_BANKS   (NUM_BANKS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) merge_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .ord_push      (ord_push),
        .ord_source    (ord_source),
        .rsp_valid     (bank_rsp_valid),
        .rsp_data      (bank_rsp_data),
        .rsp_take      (bank_rsp_take),
        .con_rsp_valid (con_rsp_valid),
        .con_rsp_data  (con_rsp_data),
        .con_rsp_take  (con_rsp_take),
        .bus_read_done (bus_read_done),
        .bus_read_data (bus_read_data)
    );

endmodule

`default_nettype wire

// ==== design/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // ====================
    // bus widths
    // ====================
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // word location and register offset field widths
    localparam int WORD_W = 26;
    localparam int OFS_W  = 28;

    // ====================
    // address map
    // ====================
    // region nibble 0 is ram, anything else hits the console block
    localparam logic [3:0] RAM_REGION = 4'h0;
    // console register offsets
    localparam logic [OFS_W-1:0] KEY_OFS  = OFS_W'(0);
    localparam logic [OFS_W-1:0] UART_OFS = OFS_W'(4);

    typedef logic [DATA_W-1:0] data_t;

    // one bus address, two decodes
    typedef union packed {
        // ram location, low word bits pick the bank
        struct packed {
            logic [3:0]        region;
            logic [WORD_W-1:0] word;
            logic [1:0]        byte_ofs;
        } ram;
        // console register location
        struct packed {
            logic [3:0]       region;
            logic [OFS_W-1:0] offset;
        } mmio;
    } bus_addr_u;

    // circular pointer advance for the small queues
    function automatic int wrap_inc(input int ptr, input int depth);
        return (ptr == depth - 1) ? 0 : ptr + 1;
    endfunction

endpackage

`default_nettype wire

// ==== design/console_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module console_regs
    import bus_pkg::*;
(
    input  wire logic             CLOCK_50,
    input  wire logic             KEY0,
    input  wire logic             req_valid,
    input  wire logic             req_write,
    input  wire logic [OFS_W-1:0] req_offset,
    input  wire data_t            req_data,
    output logic                  credit_return,
    output logic                  rsp_valid,
    output data_t                 rsp_data,
    input  wire logic             rsp_take,
    // keyboard in
    input  wire logic             key_valid,
    input  wire logic [7:0]       key_ascii,
    // interrupt and uart out
    output logic                  irq,
    output logic                  uart_valid,
    output logic [7:0]            uart_data
);

    logic [7:0] key_char;
    logic       is_read;
    logic       key_read;
    logic       uart_write;
    logic       rsp_release;

    assign is_read     = req_valid && !req_write;
    assign key_read    = is_read && (req_offset == KEY_OFS);
    assign uart_write  = req_valid && req_write && (req_offset == UART_OFS);
    assign rsp_release = rsp_valid && rsp_take;
    // writes finish on arrival, reads once the merger takes them
    assign credit_return = (req_valid && req_write) || rsp_release;

    // ====================
    // keyboard, irq, uart
    // ====================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_char   <= '0;
            irq        <= 1'b0;
            uart_valid <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            if (key_valid) begin
                key_char <= key_ascii;
            end
            // new key wins over a clearing read
            if (key_valid) begin
                irq <= 1'b1;
            end else if (key_read) begin
                irq <= 1'b0;
            end
            // one cycle pulse per transmit write
            uart_valid <= uart_write;
            if (is_read) begin
                rsp_valid <= 1'b1;
            end else if (rsp_release) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (uart_write) begin
            uart_data <= req_data[7:0];
        end
        // unknown offsets read as zero
        if (is_read) begin
            rsp_data <= key_read ? DATA_W'(key_char) : '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/ram_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module ram_bank
    import bus_pkg::*;
#(
    parameter int BANK_WORDS  = 64,
    parameter int QUEUE_DEPTH = 2,
    localparam int INDEX_W    = $clog2(BANK_WORDS),
    localparam int PTR_W      = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1,
    localparam int CNT_W      = $clog2(QUEUE_DEPTH + 1)
) (
    input  wire logic               CLOCK_50,
    input  wire logic               KEY0,
    input  wire logic               req_valid,
    input  wire logic               req_write,
    input  wire logic [INDEX_W-1:0] req_index,
    input  wire data_t              req_data,
    output logic                    credit_return,
    output logic                    rsp_valid,
    output data_t                   rsp_data,
    input  wire logic               rsp_take
);

    data_t              mem [BANK_WORDS];
    // request queue, one slot per credit
    logic               q_write [QUEUE_DEPTH];
    logic [INDEX_W-1:0] q_index [QUEUE_DEPTH];
    data_t              q_data  [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               head_write;
    logic               rsp_release;
    logic               pop;

    assign head_write  = q_write[rd_ptr];
    assign rsp_release = rsp_valid && rsp_take;
    // reads need an empty response register
    // writes hold off while a read is released, one credit per cycle
    assign pop = (count != '0) && (head_write ? !rsp_release : !rsp_valid);
    assign credit_return = (pop && head_write) || rsp_release;

    // ====================
    // queue control
    // ====================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            rsp_valid <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= PTR_W'(wrap_inc(int'(wr_ptr), QUEUE_DEPTH));
            end
            if (pop) begin
                rd_ptr <= PTR_W'(wrap_inc(int'(rd_ptr), QUEUE_DEPTH));
            end
            count <= count + CNT_W'(req_valid) - CNT_W'(pop);
            // response held until the merger takes it
            if (pop && !head_write) begin
                rsp_valid <= 1'b1;
            end else if (rsp_release) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // ====================
    // storage
    // ====================
    always_ff @(posedge CLOCK_50) begin
        if (req_valid) begin
            q_write[wr_ptr] <= req_write;
            q_index[wr_ptr] <= req_index;
            q_data[wr_ptr]  <= req_data;
        end
        if (pop) begin
            if (head_write) begin
                mem[q_index[rd_ptr]] <= q_data[rd_ptr];
            end else begin
                rsp_data <= mem[q_index[rd_ptr]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/read_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_merge
    import bus_pkg::*;
#(
    parameter int NUM_BANKS   = 4,
    parameter int QUEUE_DEPTH = 2,
    localparam int SRC_W      = $clog2(NUM_BANKS + 1),
    // every outstanding read holds a credit
    localparam int ORD_DEPTH  = NUM_BANKS * QUEUE_DEPTH + 1,
    localparam int PTR_W      = $clog2(ORD_DEPTH),
    localparam int CNT_W      = $clog2(ORD_DEPTH + 1)
) (
    input  wire logic                 CLOCK_50,
    input  wire logic                 KEY0,
    input  wire logic                 ord_push,
    input  wire logic [SRC_W-1:0]     ord_source,
    // bank responses
    input  wire logic [NUM_BANKS-1:0] rsp_valid,
    input  wire data_t                rsp_data [NUM_BANKS],
    output logic [NUM_BANKS-1:0]      rsp_take,
    // console response
    input  wire logic                 con_rsp_valid,
    input  wire data_t                con_rsp_data,
    output logic                      con_rsp_take,
    // cpu return
    output logic                      bus_read_done,
    output data_t                     bus_read_data
);

    logic [SRC_W-1:0] ord_fifo [ORD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [SRC_W-1:0] head_src;
    logic [NUM_BANKS:0] src_valid;
    data_t            src_data [NUM_BANKS+1];
    logic             take;

    // ====================
    // source select
    // ====================
    // console is the top source number
    assign src_valid = {con_rsp_valid, rsp_valid};

    always_comb begin
        for (int s = 0; s < NUM_BANKS; s++) begin
            src_data[s] = rsp_data[s];
        end
        src_data[NUM_BANKS] = con_rsp_data;
    end

    // oldest read only, younger responses wait in their banks
    assign head_src = ord_fifo[rd_ptr];
    assign take     = (count != '0) && src_valid[head_src];

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            rsp_take[b] = take && (head_src == SRC_W'(b));
        end
    end
    assign con_rsp_take = take && (head_src == SRC_W'(NUM_BANKS));

    // ====================
    // order fifo
    // ====================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            bus_read_done <= 1'b0;
        end else begin
            if (ord_push) begin
                wr_ptr <= PTR_W'(wrap_inc(int'(wr_ptr), ORD_DEPTH));
            end
            if (take) begin
                rd_ptr <= PTR_W'(wrap_inc(int'(rd_ptr), ORD_DEPTH));
            end
            count         <= count + CNT_W'(ord_push) - CNT_W'(take);
            // done lands the cycle after the take
            bus_read_done <= take;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (ord_push) begin
            ord_fifo[wr_ptr] <= ord_source;
        end
        if (take) begin
            bus_read_data <= src_data[head_src];
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bus fabric testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module bus_fabric_tb -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench prints its verdict
output=$(./obj_dir/Vbus_fabric_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== tb.f ====
design/bus_pkg.sv
design/bus_decoder.sv
design/ram_bank.sv
design/console_regs.sv
design/read_merge.sv
design/bus_fabric_top.sv
tb/tb_clock_gen.sv
tb/bus_fabric_chk.sv
tb/bus_fabric_tb.sv

// ==== tb/bus_fabric_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_fabric_chk (
    input wire logic CLOCK_50,
    input wire logic KEY0,
    input wire logic bus_read_enable,
    input wire logic bus_write_enable,
    input wire logic bus_ready,
    input wire logic bus_read_done,
    input wire logic uart_valid
);

    int unsigned outstanding;
    int          assert_fails = 0;
    logic        read_accept;

    // read handshake as seen on the cpu port
    assign read_accept = bus_read_enable && !bus_write_enable && bus_ready;

    // ====================
    // outstanding reads
    // ====================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + 32'(read_accept) - 32'(bus_read_done);
        end
    end

    // every done pulse needs an accepted read behind it
    done_needs_read: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_done |-> (outstanding != 0))
    else begin
        assert_fails++;
        $error("bus_read_done with no read outstanding");
    end

    // transmit strobe is a single cycle
    uart_single_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_valid |=> !uart_valid)
    else begin
        assert_fails++;
        $error("uart_valid held for two cycles");
    end

    // quiet outputs in reset
    reset_quiet: assert property (@(posedge CLOCK_50)
        !KEY0 |-> (!bus_read_done && !uart_valid))
    else begin
        assert_fails++;
        $error("bus_read_done or uart_valid high during reset");
    end

endmodule

`default_nettype wire

// ==== tb/bus_fabric_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_fabric_tb
    import bus_pkg::*;
();

    localparam int NUM_BANKS   = 4;
    localparam int BANK_WORDS  = 64;
    localparam int QUEUE_DEPTH = 2;
    localparam int RAM_WORDS   = NUM_BANKS * BANK_WORDS;
    localparam int WAIT_LIMIT  = 50;
    localparam logic [31:0] RAND_SEED = 32'h810760e3;

    logic              CLOCK_50;
    logic              KEY0;
    logic [ADDR_W-1:0] bus_address;
    data_t             bus_write_data;
    logic              bus_write_enable;
    logic              bus_read_enable;
    logic              bus_ready;
    logic              bus_read_done;
    data_t             bus_read_data;
    logic              key_valid;
    logic [7:0]        key_ascii;
    logic              irq;
    logic              uart_valid;
    logic [7:0]        uart_data;

    int    errors = 0;
    int    done_count = 0;
    // expected read data with the oldest at the front
    data_t exp_q [$];
    // reference ram indexed by word location
    data_t ref_mem [RAM_WORDS];
    int    written [$];

    tb_clock_gen clock_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    bus_fabric_top #(
        .NUM_BANKS   (NUM_BANKS),
        .BANK_WORDS  (BANK_WORDS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_ready        (bus_ready),
        .bus_read_done    (bus_read_done),
        .bus_read_data    (bus_read_data),
        .key_valid        (key_valid),
        .key_ascii        (key_ascii),
        .irq              (irq),
        .uart_valid       (uart_valid),
        .uart_data        (uart_data)
    );

    bind bus_fabric_top bus_fabric_chk chk_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_ready        (bus_ready),
        .bus_read_done    (bus_read_done),
        .uart_valid       (uart_valid)
    );

    // ====================
    // compare tasks
    // ====================
    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    // ====================
    // address helpers
    // ====================
    function automatic logic [ADDR_W-1:0] ram_addr(input int w);
        bus_addr_u a;
        a.ram.region   = RAM_REGION;
        a.ram.word     = WORD_W'(w);
        a.ram.byte_ofs = 2'b00;
        return a;
    endfunction

    // console space in region 1
    function automatic logic [ADDR_W-1:0] con_addr(input logic [OFS_W-1:0] ofs);
        bus_addr_u a;
        a.mmio.region = 4'h1;
        a.mmio.offset = ofs;
        return a;
    endfunction

    // ====================
    // bus driving
    // ====================
    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLOCK_50);
        #1;
    endtask

    // data is write data or the expected read data
    task automatic send_request(input logic wr, input logic [ADDR_W-1:0] addr,
                                input data_t data, output int stalls);
        int   waited;
        logic accepted;
        waited           = 0;
        accepted         = 1'b0;
        bus_address      = addr;
        bus_write_data   = wr ? data : '0;
        bus_write_enable = wr;
        bus_read_enable  = !wr;
        while (!accepted && waited < WAIT_LIMIT) begin
            // ready is settled mid cycle
            #1;
            accepted = bus_ready;
            next_cycle();
            waited++;
        end
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        stalls           = waited - 1;
        if (!accepted) begin
            errors++;
            $display("request to address %h was never accepted", addr);
        end else if (!wr) begin
            exp_q.push_back(data);
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT * 4) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timed out with %0d reads still unanswered", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic press_key(input logic [7:0] ch);
        int waited;
        key_ascii = ch;
        key_valid = 1'b1;
        next_cycle();
        key_valid = 1'b0;
        waited    = 0;
        while (!irq && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!irq) begin
            errors++;
            $display("irq did not rise after a key press");
        end
    endtask

    // read responses sampled mid cycle
    always @(negedge CLOCK_50) begin
        if (KEY0 && bus_read_done) begin
            done_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("read response arrived with no read outstanding");
            end else begin
                check_data("bus_read_data", bus_read_data, exp_q.pop_front());
            end
        end
    end

    // ====================
    // directed tests
    // ====================
    task automatic test_reset_state();
        check_flag("bus_ready", bus_ready, 1'b1);
        check_flag("bus_read_done", bus_read_done, 1'b0);
        check_flag("uart_valid", uart_valid, 1'b0);
        check_flag("irq", irq, 1'b0);
    endtask

    task automatic test_write_read();
        data_t d;
        int    stalls;
        written.delete();
        // both ends of every bank
        for (int b = 0; b < NUM_BANKS; b++) begin
            written.push_back(b);
            written.push_back((BANK_WORDS - 1) * NUM_BANKS + b);
        end
        for (int k = 0; k < 8; k++) begin
            written.push_back(int'($urandom_range(RAM_WORDS - 1)));
        end
        foreach (written[i]) begin
            d = $urandom();
            ref_mem[written[i]] = d;
            send_request(1'b1, ram_addr(written[i]), d, stalls);
        end
        foreach (written[i]) begin
            send_request(1'b0, ram_addr(written[i]), ref_mem[written[i]], stalls);
        end
        wait_drained();
    endtask

    task automatic test_back_to_back();
        data_t d;
        int    stalls;
        int    bank_stalls;
        int    start_count;
        int    n_reads;
        for (int w = 0; w < 24; w++) begin
            d = $urandom();
            ref_mem[w] = d;
            send_request(1'b1, ram_addr(w), d, stalls);
        end
        start_count = done_count;
        n_reads     = 0;
        bank_stalls = 0;
        // one bank only until its credits run out
        for (int k = 0; k < 6; k++) begin
            send_request(1'b0, ram_addr(1 + NUM_BANKS * k), ref_mem[1 + NUM_BANKS * k],
                         stalls);
            bank_stalls += stalls;
            n_reads++;
        end
        // interleaved over all banks
        for (int w = 0; w < 16; w++) begin
            send_request(1'b0, ram_addr(w), ref_mem[w], stalls);
            n_reads++;
        end
        wait_drained();
        check_flag("bus_ready stall on one bank", bank_stalls != 0, 1'b1);
        check_data("read done count", DATA_W'(done_count - start_count), DATA_W'(n_reads));
    endtask

    task automatic test_keyboard();
        logic [7:0] ch;
        int         stalls;
        ch = 8'($urandom());
        press_key(ch);
        // character comes back zero extended
        send_request(1'b0, con_addr(KEY_OFS), DATA_W'(ch), stalls);
        wait_drained();
        check_flag("irq", irq, 1'b0);
    endtask

    task automatic test_uart_unknown();
        data_t d;
        int    stalls;
        int    pulses;
        d = $urandom();
        send_request(1'b1, con_addr(UART_OFS), d, stalls);
        pulses = 0;
        for (int c = 0; c < 8; c++) begin
            if (uart_valid) begin
                pulses++;
                check_byte("uart_data", uart_data, d[7:0]);
            end
            next_cycle();
        end
        if (pulses != 1) begin
            errors++;
            $display("expected one uart_valid pulse after the write, saw %0d", pulses);
        end
        // unknown offset reads as zero
        send_request(1'b0, con_addr(OFS_W'(16)), '0, stalls);
        wait_drained();
        // offset bits alias ram word 5
        press_key(8'h5a);
        send_request(1'b1, con_addr(OFS_W'(20)), $urandom(), stalls);
        for (int c = 0; c < 4; c++) begin
            next_cycle();
        end
        check_flag("irq", irq, 1'b1);
        send_request(1'b0, ram_addr(5), ref_mem[5], stalls);
        wait_drained();
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int waited;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        key_valid        = 1'b0;
        key_ascii        = '0;
        void'($urandom(RAND_SEED));
        waited = 0;
        while (KEY0 !== 1'b1 && waited < 20) begin
            next_cycle();
            waited++;
        end
        if (KEY0 !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end
        next_cycle();
        test_reset_state();
        test_write_read();
        test_back_to_back();
        test_keyboard();
        test_uart_unknown();
        for (int c = 0; c < 4; c++) begin
            next_cycle();
        end
        $display("errors %0d, assertion failures %0d", errors, dut_i.chk_i.assert_fails);
        if (errors == 0 && dut_i.chk_i.assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // overall limit on the run
    initial begin
        repeat (20000) @(posedge CLOCK_50);
        $display("simulation did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic CLOCK_50,
    output logic KEY0
);

    // 20 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        KEY0 = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
    end

endmodule

`default_nettype wire
